//--- Bender.yml
package:
  name: fetch_top

sources:
  - hdl/fetch_pkg.sv
  - hdl/icache_array.sv
  - hdl/burst_read_master.sv
  - hdl/fetch_unit.sv
  - hdl/fetch_top.sv
  - target: simulation
    files:
      - verif/axi_read_mem.sv
      - verif/tb_fetch_top.sv

//--- build.f
hdl/fetch_pkg.sv
hdl/icache_array.sv
hdl/burst_read_master.sv
hdl/fetch_unit.sv
hdl/fetch_top.sv
verif/axi_read_mem.sv
verif/tb_fetch_top.sv

//--- hdl/burst_read_master.sv
`timescale 1ns/1ps

module burst_read_master import fetch_pkg::*; (
  input  logic       clock,
  input  logic       reset,

  input  logic       line_request,
  input  addr_t      line_address,
  output logic       line_done,
  output line_t      line_data,

  // AXI4 read address channel.
  output addr_t      araddr,
  output logic [7:0] arlen,
  output logic [2:0] arsize,
  output logic [1:0] arburst,
  output logic       arvalid,
  input  logic       arready,

  // AXI4 read data channel.
  input  word_t      rdata,
  input  logic [1:0] rresp,
  input  logic       rlast,
  input  logic       rvalid,
  output logic       rready
);

  typedef enum logic [1:0] {
    bus_idle,
    bus_address,
    bus_data
  } bus_state_t;

  bus_state_t state;
  word_t      beat0;   // First beat of the line.

  // Fixed burst shape: one line of 32-bit INCR beats.
  assign arlen   = 8'(line_words - 1);
  assign arsize  = 3'd2;
  assign arburst = 2'b01;

  // Last beat completes the line straight from the bus.
  assign line_done = rready & rvalid & rlast;
  assign line_data = {rdata, beat0};

  // ----------------------------------------
  // Sequencer
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= bus_idle;
      arvalid <= 1'b0;
      rready  <= 1'b0;
    end else begin
      case (state)
        bus_idle: begin
          if (line_request) begin
            arvalid <= 1'b1;
            state   <= bus_address;
          end
        end
        bus_address: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= bus_data;
          end
        end
        bus_data: begin
          if (rvalid && rlast) begin
            rready <= 1'b0;
            state  <= bus_idle;
          end
        end
        default: state <= bus_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == bus_idle && line_request) begin
      araddr <= line_address;   // Held stable until arready.
    end
    if (rready && rvalid && !rlast) begin
      beat0 <= rdata;
    end
  end

endmodule

//--- hdl/fetch_pkg.sv
package fetch_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------

  typedef logic [31:0] addr_t;   // Byte address.
  typedef logic [31:0] word_t;   // One instruction or one bus beat.
  typedef logic [63:0] line_t;   // Lower word sits at the lower address.

  // Address split: tag [31:7], index [6:3], byte offset [2:0].
  typedef logic [24:0] tag_t;
  typedef logic [3:0]  index_t;

  // ----------------------------------------
  // Constants
  // ----------------------------------------

  localparam addr_t reset_pc = 32'h3000_0000;

  // On-chip SRAM lives here and is never cached.
  localparam logic [7:0] uncached_region = 8'h0f;

  localparam int unsigned line_words = 2;   // Beats per refill burst.

  // ----------------------------------------
  // Fetch FSM
  // ----------------------------------------

  typedef enum logic {
    lookup,
    refill
  } fetch_state_t;

endpackage

//--- hdl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
  parameter addr_t reset_address = reset_pc
) (
  input  logic       clock,
  input  logic       reset,

  input  logic       redirect,
  input  addr_t      redirect_pc,
  input  logic       flush,

  output logic       inst_valid,
  output word_t      inst,
  output addr_t      inst_pc,
  input  logic       inst_ready,

  output addr_t      araddr,
  output logic [7:0] arlen,
  output logic [2:0] arsize,
  output logic [1:0] arburst,
  output logic       arvalid,
  input  logic       arready,
  input  word_t      rdata,
  input  logic [1:0] rresp,
  input  logic       rlast,
  input  logic       rvalid,
  output logic       rready
);

  index_t lookup_index;
  logic   lookup_valid;
  tag_t   lookup_tag;
  line_t  lookup_line;

  logic   fill_valid;
  index_t fill_index;
  tag_t   fill_tag;
  line_t  fill_line;

  logic   line_request;
  addr_t  line_address;
  logic   line_done;
  line_t  line_data;

  fetch_unit #(
    .reset_address(reset_address)
  ) u_fetch_unit (
    .clock        (clock),
    .reset        (reset),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .inst_pc      (inst_pc),
    .inst_ready   (inst_ready),
    .lookup_index (lookup_index),
    .lookup_valid (lookup_valid),
    .lookup_tag   (lookup_tag),
    .lookup_line  (lookup_line),
    .fill_valid   (fill_valid),
    .fill_index   (fill_index),
    .fill_tag     (fill_tag),
    .fill_line    (fill_line),
    .line_request (line_request),
    .line_address (line_address),
    .line_done    (line_done),
    .line_data    (line_data)
  );

  icache_array u_icache_array (
    .clock        (clock),
    .reset        (reset),
    .flush        (flush),
    .lookup_index (lookup_index),
    .lookup_valid (lookup_valid),
    .lookup_tag   (lookup_tag),
    .lookup_line  (lookup_line),
    .fill_valid   (fill_valid),
    .fill_index   (fill_index),
    .fill_tag     (fill_tag),
    .fill_line    (fill_line)
  );

  burst_read_master u_burst_read_master (
    .clock        (clock),
    .reset        (reset),
    .line_request (line_request),
    .line_address (line_address),
    .line_done    (line_done),
    .line_data    (line_data),
    .araddr       (araddr),
    .arlen        (arlen),
    .arsize       (arsize),
    .arburst      (arburst),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rresp        (rresp),
    .rlast        (rlast),
    .rvalid       (rvalid),
    .rready       (rready)
  );

endmodule

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import fetch_pkg::*; #(
  parameter addr_t reset_address = reset_pc
) (
  input  logic   clock,
  input  logic   reset,
  input  logic   redirect,
  input  addr_t  redirect_pc,

  // Instruction stream.
  output logic   inst_valid,
  output word_t  inst,
  output addr_t  inst_pc,
  input  logic   inst_ready,

  // Cache lookup.
  output index_t lookup_index,
  input  logic   lookup_valid,
  input  tag_t   lookup_tag,
  input  line_t  lookup_line,

  // Cache fill.
  output logic   fill_valid,
  output index_t fill_index,
  output tag_t   fill_tag,
  output line_t  fill_line,

  // Line reads from memory.
  output logic   line_request,
  output addr_t  line_address,
  input  logic   line_done,
  input  line_t  line_data
);

  fetch_state_t state;
  addr_t        pc;
  addr_t        refill_pc;   // Address of the line being read.
  logic         discard;     // Redirected while the line was in flight.

  tag_t         pc_tag;
  logic         uncached;
  logic         hit;
  logic         out_free;
  logic         take_hit;
  logic         deliver;

  function automatic word_t select_word(input line_t line, input logic upper);
    word_t word;
    word = upper ? line[63:32] : line[31:0];
    return word;
  endfunction

  // ----------------------------------------
  // Hit and miss decisions
  // ----------------------------------------

  assign pc_tag       = pc[31:7];
  assign lookup_index = pc[6:3];
  assign uncached     = (pc[31:24] == uncached_region);
  assign hit          = lookup_valid && (lookup_tag == pc_tag) && !uncached;

  // Output register is empty or drains this cycle.
  assign out_free = !inst_valid || inst_ready;

  assign take_hit     = (state == lookup) && !redirect && out_free && hit;
  assign line_request = !reset && (state == lookup) && !redirect && out_free && !hit;
  assign line_address = {pc[31:3], 3'b000};

  assign deliver = (state == refill) && line_done && !discard && !redirect;

  // A stale line still goes into the cache.
  assign fill_valid = line_done && (refill_pc[31:24] != uncached_region);
  assign fill_index = refill_pc[6:3];
  assign fill_tag   = refill_pc[31:7];
  assign fill_line  = line_data;

  // ----------------------------------------
  // Control
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= lookup;
      pc         <= reset_address;
      inst_valid <= 1'b0;
      discard    <= 1'b0;
    end else if (redirect) begin
      pc         <= redirect_pc;
      inst_valid <= 1'b0;
      if (state == refill) begin
        if (line_done) begin
          state   <= lookup;
          discard <= 1'b0;
        end else begin
          discard <= 1'b1;   // Let the burst finish quietly.
        end
      end
    end else begin
      case (state)
        lookup: begin
          if (out_free) begin
            if (hit) begin
              inst_valid <= 1'b1;
              pc         <= pc + 32'd4;
            end else begin
              inst_valid <= 1'b0;
              state      <= refill;
            end
          end
        end
        refill: begin
          if (line_done) begin
            state   <= lookup;
            discard <= 1'b0;
            if (!discard) begin
              inst_valid <= 1'b1;
              pc         <= pc + 32'd4;
            end
          end
        end
        default: state <= lookup;
      endcase
    end
  end

  // ----------------------------------------
  // Payload
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (take_hit) begin
      inst    <= select_word(lookup_line, pc[2]);
      inst_pc <= pc;
    end else if (deliver) begin
      inst    <= select_word(line_data, pc[2]);   // Word picked by pc bit 2.
      inst_pc <= pc;
    end
    if (line_request) begin
      refill_pc <= pc;
    end
  end

endmodule

//--- hdl/icache_array.sv
`timescale 1ns/1ps

module icache_array import fetch_pkg::*; (
  input  logic   clock,
  input  logic   reset,
  input  logic   flush,

  input  index_t lookup_index,
  output logic   lookup_valid,
  output tag_t   lookup_tag,
  output line_t  lookup_line,

  input  logic   fill_valid,
  input  index_t fill_index,
  input  tag_t   fill_tag,
  input  line_t  fill_line
);

  localparam int entries = 2 ** $bits(index_t);

  logic [entries-1:0] valid;
  tag_t               tags  [entries];
  line_t              lines [entries];

  // Lookup is purely combinational.
  assign lookup_valid = valid[lookup_index];
  assign lookup_tag   = tags[lookup_index];
  assign lookup_line  = lines[lookup_index];

  // ----------------------------------------
  // Valid bits
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
    end else begin
      if (flush) begin
        valid <= '0;
      end
      // A fill in the flush cycle still lands.
      if (fill_valid) begin
        valid[fill_index] <= 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Tag and data storage
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (fill_valid) begin
      tags[fill_index]  <= fill_tag;
      lines[fill_index] <= fill_line;
    end
  end

endmodule

//--- verif/axi_read_mem.sv
`timescale 1ns/1ps

module axi_read_mem import fetch_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic [1:0] beat_delay,   // Wait cycles before the next beat.

  input  addr_t      araddr,
  input  logic       arvalid,
  output logic       arready,

  output word_t      rdata,
  output logic [1:0] rresp,
  output logic       rlast,
  output logic       rvalid,
  input  logic       rready
);

  typedef enum logic [1:0] {
    mem_idle,
    mem_wait,
    mem_beat
  } mem_state_t;

  mem_state_t state;
  addr_t      base;
  logic       beat;
  logic [1:0] count;

  assign rresp = 2'b00;

  // Memory content is a fixed mix of the word address.
  function automatic word_t word_at(input addr_t a);
    word_t w;
    w = {a[18:0], a[31:19]} ^ 32'ha5a5_1234;
    return w;
  endfunction

  always @(posedge clock) begin
    if (reset) begin
      state   <= mem_idle;
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rlast   <= 1'b0;
      rdata   <= '0;
    end else begin
      case (state)
        mem_idle: begin
          arready <= 1'b1;
          if (arvalid && arready) begin
            arready <= 1'b0;
            base    <= araddr;
            beat    <= 1'b0;
            count   <= beat_delay;
            state   <= mem_wait;
          end
        end
        mem_wait: begin
          if (count == 2'd0) begin
            rvalid <= 1'b1;
            rdata  <= word_at(base + {29'd0, beat, 2'b00});
            rlast  <= beat;   // Two beats per burst.
            state  <= mem_beat;
          end else begin
            count <= count - 2'd1;
          end
        end
        mem_beat: begin
          if (rready) begin
            rvalid <= 1'b0;
            rlast  <= 1'b0;
            if (rlast) begin
              state <= mem_idle;
            end else begin
              beat  <= 1'b1;
              count <= beat_delay;
              state <= mem_wait;
            end
          end
        end
        default: state <= mem_idle;
      endcase
    end
  end

endmodule

//--- verif/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top import fetch_pkg::*; ();

  logic       clock;
  logic       reset;
  logic       redirect;
  addr_t      redirect_pc;
  logic       flush;
  logic       inst_valid;
  word_t      inst;
  addr_t      inst_pc;
  logic       inst_ready;
  addr_t      araddr;
  logic [7:0] arlen;
  logic [2:0] arsize;
  logic [1:0] arburst;
  logic       arvalid;
  logic       arready;
  word_t      rdata;
  logic [1:0] rresp;
  logic       rlast;
  logic       rvalid;
  logic       rready;
  logic [1:0] beat_delay;

  logic [15:0] lfsr_state;
  addr_t       exp_pc;
  int          exp_ar;
  int          ar_count;
  int          delivered;
  int          errors;
  logic        hold_pending;
  word_t       held_inst;
  addr_t       held_pc;
  logic        model_valid [16];
  tag_t        model_tag   [16];

  fetch_top u_dut (.*);

  axi_read_mem u_mem (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] v;
    logic       fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      v = {v[6:0], fb};
    end
    return v;
  endfunction

  function automatic word_t expected_word(input addr_t a);
    word_t w;
    w = {a[18:0], a[31:19]} ^ 32'ha5a5_1234;   // Rotate left by 13.
    return w;
  endfunction

  // One fetch of address a, counting the burst it should need.
  task automatic model_fetch(input addr_t a);
    logic cached;
    cached = (a[31:24] != 8'h0f);
    if (!cached || !model_valid[a[6:3]] || model_tag[a[6:3]] != a[31:7]) begin
      exp_ar++;
      if (cached) begin
        model_valid[a[6:3]] = 1'b1;
        model_tag[a[6:3]]   = a[31:7];
      end
    end
  endtask

  task automatic abort(input string reason);
    errors++;
    $display("ERROR: %s", reason);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  // ----------------------------------------
  // One falling edge of stimulus and checks
  // ----------------------------------------

  task automatic step(input logic want_ready, input logic do_redirect,
                      input addr_t target, input logic do_flush);
    logic r;
    r = want_ready && !do_redirect;
    @(negedge clock);
    if (arvalid) begin
      compare("arlen", 32'(arlen), 32'd1);
      compare("arsize", 32'(arsize), 32'd2);
      compare("arburst", 32'(arburst), 32'd1);
      compare("araddr_low", 32'(araddr[2:0]), 32'd0);
      if (arready) ar_count++;   // Handshake on the coming edge.
    end
    if (hold_pending) begin
      compare("inst_valid", 32'(inst_valid), 32'd1);
      compare("inst", inst, held_inst);
      compare("inst_pc", inst_pc, held_pc);
    end
    if (inst_valid && r) begin
      model_fetch(exp_pc);
      compare("inst_pc", inst_pc, exp_pc);
      compare("inst", inst, expected_word(exp_pc));
      compare("ar_count", 32'(ar_count), 32'(exp_ar));
      exp_pc = exp_pc + 32'd4;
      delivered++;
    end
    hold_pending = inst_valid && !r && !do_redirect;
    held_inst    = inst;
    held_pc      = inst_pc;
    inst_ready   = r;
    redirect     = do_redirect;
    redirect_pc  = target;
    flush        = do_flush;
    beat_delay   = take_bits(2);
    if (do_flush) begin
      for (int i = 0; i < 16; i++) model_valid[i] = 1'b0;
    end
    if (do_redirect) exp_pc = target;
  endtask

  task automatic stream(input int n, input logic random_ready);
    int goal;
    int waited;
    goal   = delivered + n;
    waited = 0;
    while (delivered < goal) begin
      step(random_ready ? (take_bits(2) != 2'd0) : 1'b1, 1'b0, '0, 1'b0);
      waited++;
      if (waited > n * 40 + 100) abort("timeout waiting for instructions");
    end
  endtask

  // Stall until the next instruction is held, then account its fetch.
  task automatic hold_next();
    int waited;
    waited = 0;
    do begin
      step(1'b0, 1'b0, '0, 1'b0);
      waited++;
      if (waited > 200) abort("timeout waiting for a held instruction");
    end while (!inst_valid);
    model_fetch(exp_pc);
    compare("inst_pc", inst_pc, exp_pc);
    compare("inst", inst, expected_word(exp_pc));
    compare("ar_count", 32'(ar_count), 32'(exp_ar));
  endtask

  task automatic quiet_redirect(input addr_t target);
    hold_next();
    step(1'b0, 1'b1, target, 1'b0);
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    int waited;
    addr_t target;
    lfsr_state   = 16'd14458;
    reset        = 1'b1;
    redirect     = 1'b0;
    redirect_pc  = '0;
    flush        = 1'b0;
    inst_ready   = 1'b0;
    beat_delay   = 2'd0;
    exp_pc       = 32'h3000_0000;
    exp_ar       = 0;
    ar_count     = 0;
    delivered    = 0;
    errors       = 0;
    hold_pending = 1'b0;
    for (int i = 0; i < 16; i++) model_valid[i] = 1'b0;
    repeat (4) @(negedge clock);
    reset = 1'b0;

    stream(16, 1'b0);                   // Cold start, one burst per line.
    quiet_redirect(32'h3000_0000);
    stream(16, 1'b1);                   // Loop back, all hits under stalls.

    quiet_redirect(32'h0f00_0100);      // SRAM region.
    stream(8, 1'b1);
    quiet_redirect(32'h0f00_0100);
    stream(8, 1'b0);

    hold_next();                        // Flush, then rerun cached code.
    step(1'b0, 1'b0, '0, 1'b1);
    step(1'b0, 1'b1, 32'h3000_0000, 1'b0);
    stream(8, 1'b1);

    // Redirect while a refill is in flight.
    quiet_redirect(32'h3000_0800);
    waited = 0;
    while (!arvalid) begin
      step(1'b0, 1'b0, '0, 1'b0);
      waited++;
      if (waited > 50) abort("timeout waiting for the refill to start");
    end
    model_fetch(32'h3000_0800);         // The stale line still fills.
    step(1'b0, 1'b1, 32'h3000_0040, 1'b0);
    stream(8, 1'b1);
    quiet_redirect(32'h3000_0800);
    stream(4, 1'b1);

    for (int k = 0; k < 3; k++) begin
      target = 32'h3000_0000 + {22'd0, take_bits(6), 2'b00};
      quiet_redirect(target);
      stream(6, 1'b1);
    end

    hold_next();
    repeat (2) step(1'b0, 1'b0, '0, 1'b0);
    compare("ar_count", 32'(ar_count), 32'(exp_ar));

    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
